// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_pipelined_controller
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -F -q "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: cond_unit.sv
`timescale 1ns/1ps

module cond_unit import ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  cond_e              cond,
    input  logic [FLAGS_W-1:0] flags,
    input  logic               flag_we,
    output logic               cond_met_e
);

    logic zero_q;
    logic cond_met_d;

    // zero flag, written by data processing ops with the s bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            zero_q <= 1'b0;
        end else if (flag_we) begin
            zero_q <= flags[ZERO_FLAG_BIT];
        end
    end

    always_comb begin
        case (cond)
            COND_EQ: cond_met_d = zero_q;
            COND_NE: cond_met_d = ~zero_q;
            COND_AL: cond_met_d = 1'b1;
            default: cond_met_d = 1'b1;   // unsupported codes run unconditionally
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cond_met_e <= 1'b0;
        end else begin
            cond_met_e <= cond_met_d;
        end
    end

endmodule

// File: ctrl_pipeline.sv
`timescale 1ns/1ps

module ctrl_pipeline import ctrl_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush_e,
    input  ctrl_word_t ctrl_d,
    input  logic       cond_met_e,
    output exec_out_t  exec_out,
    output logic       mem_we,
    output wb_out_t    wb_out,
    output logic       branch_taken_e,
    output hazard_t    hazard
);

    ctrl_word_t ex_q;       // execute stage control word
    wb_out_t    mem_q;      // memory stage fields that continue to writeback
    logic       mem_we_q;
    wb_out_t    wb_q;

    // execute register
    always_ff @(posedge clk) begin
        if (!rst_n || flush_e) begin
            ex_q <= '0;
        end else begin
            ex_q <= ctrl_d;
        end
    end

    // memory register, a failed condition cancels the instruction here
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_q    <= '0;
            mem_we_q <= 1'b0;
        end else begin
            mem_q.reg_we     <= ex_q.reg_we && cond_met_e;
            mem_q.r14_sel    <= ex_q.r14_sel && cond_met_e;
            mem_q.mem_to_reg <= ex_q.mem_to_reg && cond_met_e;
            mem_we_q         <= ex_q.mem_we && cond_met_e;
            if (flush_e) begin
                mem_q.pc_sel <= 1'b0;            // only pc select sees the flush
            end else begin
                mem_q.pc_sel <= ex_q.pc_sel && cond_met_e;
            end
        end
    end

    // writeback register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= mem_q;
        end
    end

    assign exec_out.alu_src  = ex_q.alu_src;
    assign exec_out.alu_ctrl = ex_q.alu_ctrl;

    assign branch_taken_e = ex_q.branch_sel && cond_met_e;
    assign mem_we         = mem_we_q;
    assign wb_out         = wb_q;

    // taps for the hazard unit
    assign hazard.reg_we_m       = mem_q.reg_we;
    assign hazard.reg_we_w       = wb_q.reg_we;
    assign hazard.mem_to_reg_e   = ex_q.mem_to_reg;   // load-use detection
    assign hazard.branch_taken_e = branch_taken_e;
    assign hazard.pc_src_d       = ctrl_d.pc_sel;
    assign hazard.pc_src_e       = ex_q.pc_sel;
    assign hazard.pc_src_m       = mem_q.pc_sel;
    assign hazard.pc_src_w       = wb_q.pc_sel;

endmodule

// File: ctrl_pkg.sv
package ctrl_pkg;

    // instruction field widths
    localparam int OP_W       = 2;
    localparam int FUNCT_W    = 6;
    localparam int COND_W     = 4;
    localparam int FLAGS_W    = 4;
    localparam int ALU_CTRL_W = 4;
    localparam int EXT_SEL_W  = 2;

    localparam int ZERO_FLAG_BIT = 0;  // z bit inside the alu flags
    localparam int SET_FLAGS_BIT = 0;  // funct bit that requests a flag update

    typedef enum logic [OP_W-1:0] {
        OP_DATA   = 2'b00,
        OP_MEM    = 2'b01,
        OP_BRANCH = 2'b10
    } op_e;

    typedef enum logic [ALU_CTRL_W-1:0] {
        ALU_AND = 4'b0000,
        ALU_SUB = 4'b0010,
        ALU_ADD = 4'b0100,
        ALU_CMP = 4'b0110,
        ALU_ORR = 4'b1100,
        ALU_MOV = 4'b1101
    } alu_ctrl_e;

    typedef enum logic [COND_W-1:0] {
        COND_EQ = 4'b0000,
        COND_NE = 4'b0001,
        COND_AL = 4'b1110
    } cond_e;

    typedef enum logic [EXT_SEL_W-1:0] {
        EXT_DATA   = 2'b00,
        EXT_MEM    = 2'b01,
        EXT_BRANCH = 2'b10
    } ext_sel_e;

    // data processing funct codes
    localparam logic [FUNCT_W-1:0] FUNCT_ADD     = 6'b010000;
    localparam logic [FUNCT_W-1:0] FUNCT_SUB     = 6'b000100;
    localparam logic [FUNCT_W-1:0] FUNCT_AND     = 6'b000000;
    localparam logic [FUNCT_W-1:0] FUNCT_ORR     = 6'b011000;
    localparam logic [FUNCT_W-1:0] FUNCT_MOV     = 6'b011010;
    localparam logic [FUNCT_W-1:0] FUNCT_MOV_IMM = 6'b111010;
    localparam logic [FUNCT_W-1:0] FUNCT_CMP     = 6'b010101;

    // memory funct codes
    localparam logic [FUNCT_W-1:0] FUNCT_STR = 6'b011000;
    localparam logic [FUNCT_W-1:0] FUNCT_LDR = 6'b011001;

    // branch funct codes, bl only looks at the top two bits
    localparam logic [FUNCT_W-1:0] FUNCT_B         = 6'b100000;
    localparam logic [FUNCT_W-1:0] FUNCT_BX        = 6'b010010;
    localparam logic [1:0]         FUNCT_BL_PREFIX = 2'b11;

    typedef struct packed {
        logic     ra1_sel;
        logic     ra2_sel;
        ext_sel_e ext_sel;
        logic     shift_in_sel;
        logic     shift_type_sel;
        logic     shift_amt_sel;
    } dp_sel_t;

    typedef struct packed {
        logic      pc_sel;
        logic      branch_sel;   // set for plain b only
        logic      reg_we;
        logic      r14_sel;
        logic      alu_src;
        logic      mem_to_reg;
        logic      mem_we;
        alu_ctrl_e alu_ctrl;
    } ctrl_word_t;

    typedef struct packed {
        logic      alu_src;
        alu_ctrl_e alu_ctrl;
    } exec_out_t;

    typedef struct packed {
        logic pc_sel;
        logic reg_we;
        logic r14_sel;
        logic mem_to_reg;
    } wb_out_t;

    typedef struct packed {
        logic reg_we_m;
        logic reg_we_w;
        logic mem_to_reg_e;
        logic branch_taken_e;
        logic pc_src_d;
        logic pc_src_e;
        logic pc_src_m;
        logic pc_src_w;
    } hazard_t;

endpackage

// File: instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder import ctrl_pkg::*; (
    input  op_e                op,
    input  logic [FUNCT_W-1:0] funct,
    output dp_sel_t            dp_sel,
    output ctrl_word_t         ctrl_d,
    output logic               flag_we
);

    // any data processing op with the s bit updates the zero flag
    assign flag_we = (op == OP_DATA) && funct[SET_FLAGS_BIT];

    always_comb begin
        // unknown encodings fall through as a no-op
        dp_sel          = '0;
        dp_sel.ext_sel  = EXT_DATA;
        ctrl_d          = '0;
        ctrl_d.alu_ctrl = ALU_ADD;

        case (op)
            OP_DATA: begin
                case (funct)
                    FUNCT_ADD: begin
                        ctrl_d.reg_we   = 1'b1;
                        ctrl_d.alu_ctrl = ALU_ADD;
                    end
                    FUNCT_SUB: begin
                        ctrl_d.reg_we   = 1'b1;
                        ctrl_d.alu_ctrl = ALU_SUB;
                    end
                    FUNCT_AND: begin
                        ctrl_d.reg_we   = 1'b1;
                        ctrl_d.alu_ctrl = ALU_AND;
                    end
                    FUNCT_ORR: begin
                        ctrl_d.reg_we   = 1'b1;
                        ctrl_d.alu_ctrl = ALU_ORR;
                    end
                    FUNCT_MOV: begin
                        ctrl_d.reg_we   = 1'b1;
                        ctrl_d.alu_ctrl = ALU_MOV;
                    end
                    FUNCT_MOV_IMM: begin
                        dp_sel.shift_in_sel   = 1'b1;  // rotated immediate into shifter
                        dp_sel.shift_type_sel = 1'b1;
                        dp_sel.shift_amt_sel  = 1'b1;
                        ctrl_d.reg_we         = 1'b1;
                        ctrl_d.alu_src        = 1'b1;
                        ctrl_d.alu_ctrl       = ALU_MOV;
                    end
                    FUNCT_CMP: begin
                        ctrl_d.alu_ctrl = ALU_CMP;     // flags only, no register write
                    end
                    default: ;
                endcase
            end

            OP_MEM: begin
                case (funct)
                    FUNCT_STR: begin
                        dp_sel.ra2_sel = 1'b1;         // read rd as store data
                        dp_sel.ext_sel = EXT_MEM;
                        ctrl_d.alu_src = 1'b1;
                        ctrl_d.mem_we  = 1'b1;
                    end
                    FUNCT_LDR: begin
                        dp_sel.ra2_sel    = 1'b1;
                        dp_sel.ext_sel    = EXT_MEM;
                        ctrl_d.alu_src    = 1'b1;
                        ctrl_d.reg_we     = 1'b1;
                        ctrl_d.mem_to_reg = 1'b1;
                    end
                    default: ;
                endcase
            end

            OP_BRANCH: begin
                case (funct)
                    FUNCT_B: begin
                        dp_sel.ra1_sel    = 1'b1;      // pc as base operand
                        dp_sel.ext_sel    = EXT_BRANCH;
                        ctrl_d.pc_sel     = 1'b1;
                        ctrl_d.branch_sel = 1'b1;
                        ctrl_d.alu_src    = 1'b1;
                    end
                    FUNCT_BX: begin
                        dp_sel.ext_sel  = EXT_BRANCH;
                        ctrl_d.pc_sel   = 1'b1;
                        ctrl_d.alu_ctrl = ALU_MOV;     // target comes from a register
                    end
                    default: begin
                        if (funct[FUNCT_W-1 -: 2] == FUNCT_BL_PREFIX) begin
                            dp_sel.ra1_sel = 1'b1;
                            dp_sel.ext_sel = EXT_BRANCH;
                            ctrl_d.pc_sel  = 1'b1;
                            ctrl_d.reg_we  = 1'b1;
                            ctrl_d.r14_sel = 1'b1;     // link address goes to r14
                            ctrl_d.alu_src = 1'b1;
                        end
                    end
                endcase
            end

            default: ;
        endcase
    end

endmodule

// File: pipelined_controller.sv
`timescale 1ns/1ps

module pipelined_controller import ctrl_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    // instruction fields and alu flags
    input  op_e                op,
    input  logic [FUNCT_W-1:0] funct,
    input  cond_e              cond,
    input  logic [FLAGS_W-1:0] flags,
    input  logic               flush_e,    // from hazard unit
    // datapath controls
    output dp_sel_t            dp_sel,
    output exec_out_t          exec_out,
    output logic               mem_we,
    output wb_out_t            wb_out,
    output logic               branch_taken_e,
    // hazard unit taps
    output hazard_t            hazard
);

    ctrl_word_t ctrl_d;
    logic       flag_we;
    logic       cond_met_e;

    instr_decoder instr_decoder_inst (
        .op      (op),
        .funct   (funct),
        .dp_sel  (dp_sel),
        .ctrl_d  (ctrl_d),
        .flag_we (flag_we)
    );

    cond_unit cond_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cond       (cond),
        .flags      (flags),
        .flag_we    (flag_we),
        .cond_met_e (cond_met_e)
    );

    ctrl_pipeline ctrl_pipeline_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .flush_e        (flush_e),
        .ctrl_d         (ctrl_d),
        .cond_met_e     (cond_met_e),
        .exec_out       (exec_out),
        .mem_we         (mem_we),
        .wb_out         (wb_out),
        .branch_taken_e (branch_taken_e),
        .hazard         (hazard)
    );

endmodule

// File: tb_pipelined_controller.sv
`timescale 1ns/1ps

module tb_pipelined_controller import ctrl_pkg::*; ();

    localparam logic [FUNCT_W-1:0] NOP_FUNCT = 6'b100010;  // matches no data op and has s bit clear
    localparam logic [FUNCT_W-1:0] BL_FUNCT  = 6'b110101;  // low four bits are don't care

    localparam int IDX_ADD = 0;
    localparam int IDX_STR = 7;
    localparam int IDX_LDR = 8;
    localparam int IDX_B   = 9;
    localparam int IDX_BL  = 10;
    localparam int NUM_INSTR = 12;

    localparam int TEST_CYCLES    = 112;  // reset plus 27 instructions at about 4 cycles each
    localparam int TIMEOUT_CYCLES = 3 * TEST_CYCLES;

    typedef struct packed {
        op_e                op;
        logic [FUNCT_W-1:0] funct;
        dp_sel_t            dp;
        ctrl_word_t         cw;
    } decode_row_t;

    logic               clk;
    logic               rst_n;
    op_e                op;
    logic [FUNCT_W-1:0] funct;
    cond_e              cond;
    logic [FLAGS_W-1:0] flags;
    logic               flush_e;
    dp_sel_t            dp_sel;
    exec_out_t          exec_out;
    logic               mem_we;
    wb_out_t            wb_out;
    logic               branch_taken_e;
    hazard_t            hazard;

    int cycle_count = 0;
    int error_count = 0;
    int test_errors = 0;
    int pass_count  = 0;
    int fail_count  = 0;

    pipelined_controller pipelined_controller_inst (
        .clk            (clk),
        .rst_n          (rst_n),
        .op             (op),
        .funct          (funct),
        .cond           (cond),
        .flags          (flags),
        .flush_e        (flush_e),
        .dp_sel         (dp_sel),
        .exec_out       (exec_out),
        .mem_we         (mem_we),
        .wb_out         (wb_out),
        .branch_taken_e (branch_taken_e),
        .hazard         (hazard)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // expected decode with one row per instruction
    function automatic decode_row_t decode_row(input int idx);
        decode_row_t row;
        row = '0;
        //                                     ra1 ra2 ext sh    pc br we r14 src m2r mwe
        case (idx)
            0:  row = {OP_DATA,   FUNCT_ADD,     7'b0_0_00_000, 7'b0_0_1_0_0_0_0, ALU_ADD};
            1:  row = {OP_DATA,   FUNCT_SUB,     7'b0_0_00_000, 7'b0_0_1_0_0_0_0, ALU_SUB};
            2:  row = {OP_DATA,   FUNCT_AND,     7'b0_0_00_000, 7'b0_0_1_0_0_0_0, ALU_AND};
            3:  row = {OP_DATA,   FUNCT_ORR,     7'b0_0_00_000, 7'b0_0_1_0_0_0_0, ALU_ORR};
            4:  row = {OP_DATA,   FUNCT_MOV,     7'b0_0_00_000, 7'b0_0_1_0_0_0_0, ALU_MOV};
            5:  row = {OP_DATA,   FUNCT_MOV_IMM, 7'b0_0_00_111, 7'b0_0_1_0_1_0_0, ALU_MOV};
            6:  row = {OP_DATA,   FUNCT_CMP,     7'b0_0_00_000, 7'b0_0_0_0_0_0_0, ALU_CMP};
            7:  row = {OP_MEM,    FUNCT_STR,     7'b0_1_01_000, 7'b0_0_0_0_1_0_1, ALU_ADD};
            8:  row = {OP_MEM,    FUNCT_LDR,     7'b0_1_01_000, 7'b0_0_1_0_1_1_0, ALU_ADD};
            9:  row = {OP_BRANCH, FUNCT_B,       7'b1_0_10_000, 7'b1_1_0_0_1_0_0, ALU_ADD};
            10: row = {OP_BRANCH, BL_FUNCT,      7'b1_0_10_000, 7'b1_0_1_1_1_0_0, ALU_ADD};
            11: row = {OP_BRANCH, FUNCT_BX,      7'b0_0_10_000, 7'b1_0_0_0_0_0_0, ALU_MOV};
            default: row = '0;
        endcase
        return row;
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %0b, got %0b", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic check_vec(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    task automatic present_nop();
        @(posedge clk);
        op      <= OP_DATA;
        funct   <= NOP_FUNCT;
        cond    <= COND_AL;
        flags   <= '0;
        flush_e <= 1'b0;
        @(negedge clk);
    endtask

    // cmp with the s bit loads zero at the edge that samples it
    task automatic load_zero(input logic z);
        logic [FLAGS_W-1:0] fl;
        fl = '0;
        fl[ZERO_FLAG_BIT] = z;
        @(posedge clk);
        op      <= OP_DATA;
        funct   <= FUNCT_CMP;
        cond    <= COND_AL;
        flags   <= fl;
        flush_e <= 1'b0;
        present_nop();
    endtask

    // present one instruction and follow it to writeback
    task automatic run_and_check(input int idx, input cond_e c, input logic [FLAGS_W-1:0] fl,
                                 input logic flush, input logic met);
        decode_row_t row;
        ctrl_word_t  ex;
        row = decode_row(idx);
        ex  = '0;
        if (!flush) begin
            ex = row.cw;
        end
        @(posedge clk);
        op      <= row.op;
        funct   <= row.funct;
        cond    <= c;
        flags   <= fl;
        flush_e <= flush;
        @(negedge clk);
        check_vec("dp_sel", 16'(row.dp), 16'(dp_sel));
        check_bit("hazard.pc_src_d", row.cw.pc_sel, hazard.pc_src_d);
        present_nop();                                   // execute
        check_vec("exec_out", 16'({ex.alu_src, ex.alu_ctrl}), 16'(exec_out));
        check_bit("branch_taken_e", ex.branch_sel & met, branch_taken_e);
        check_bit("hazard.branch_taken_e", ex.branch_sel & met, hazard.branch_taken_e);
        check_bit("hazard.pc_src_e", ex.pc_sel, hazard.pc_src_e);
        check_bit("hazard.mem_to_reg_e", ex.mem_to_reg, hazard.mem_to_reg_e);
        present_nop();                                   // memory
        check_bit("mem_we", ex.mem_we & met, mem_we);
        check_bit("hazard.reg_we_m", ex.reg_we & met, hazard.reg_we_m);
        check_bit("hazard.pc_src_m", ex.pc_sel & met, hazard.pc_src_m);
        present_nop();                                   // writeback
        check_vec("wb_out", 16'({ex.pc_sel, ex.reg_we, ex.r14_sel, ex.mem_to_reg} & {4{met}}),
                  16'(wb_out));
        check_bit("hazard.reg_we_w", ex.reg_we & met, hazard.reg_we_w);
        check_bit("hazard.pc_src_w", ex.pc_sel & met, hazard.pc_src_w);
    endtask

    task automatic finish_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("test %s: pass", name);
        end else begin
            fail_count++;
            $display("test %s: fail with %0d errors", name, test_errors);
        end
        test_errors = 0;
    endtask

    task automatic test_reset();
        check_vec("dp_sel", 16'h0, 16'(dp_sel));
        check_vec("exec_out", 16'h0, 16'(exec_out));
        check_bit("mem_we", 1'b0, mem_we);
        check_vec("wb_out", 16'h0, 16'(wb_out));
        check_bit("branch_taken_e", 1'b0, branch_taken_e);
        check_vec("hazard", 16'h0, 16'(hazard));
        finish_test("reset");
    endtask

    task automatic test_decode_table();
        for (int i = 0; i < NUM_INSTR; i++) begin
            run_and_check(i, COND_AL, '0, 1'b0, 1'b1);
        end
        finish_test("decode table");
    endtask

    task automatic test_conditions();
        load_zero(1'b1);
        run_and_check(IDX_ADD, COND_EQ, '0, 1'b0, 1'b1);
        run_and_check(IDX_ADD, COND_NE, '0, 1'b0, 1'b0);
        load_zero(1'b0);
        run_and_check(IDX_ADD, COND_EQ, '0, 1'b0, 1'b0);
        run_and_check(IDX_ADD, COND_NE, '0, 1'b0, 1'b1);
        run_and_check(IDX_STR, COND_EQ, '0, 1'b0, 1'b0);  // store cancelled
        finish_test("eq and ne conditions");
    endtask

    task automatic test_branches();
        run_and_check(IDX_B, COND_NE, '0, 1'b0, 1'b1);   // zero is clear here
        run_and_check(IDX_B, COND_EQ, '0, 1'b0, 1'b0);
        run_and_check(IDX_BL, COND_AL, '0, 1'b0, 1'b1);
        finish_test("branches");
    endtask

    task automatic test_flush();
        decode_row_t row;
        row = decode_row(IDX_B);
        run_and_check(IDX_LDR, COND_AL, '0, 1'b1, 1'b1);
        // b already in execute when the flush arrives loses its memory stage pc select
        @(posedge clk);
        op      <= row.op;
        funct   <= row.funct;
        cond    <= COND_AL;
        flags   <= '0;
        flush_e <= 1'b0;
        @(posedge clk);
        op      <= OP_DATA;
        funct   <= NOP_FUNCT;
        flush_e <= 1'b1;
        @(negedge clk);
        check_bit("hazard.pc_src_e", row.cw.pc_sel, hazard.pc_src_e);
        present_nop();                                   // flush sampled here
        check_vec("exec_out", 16'h0, 16'(exec_out));
        check_bit("hazard.pc_src_m", 1'b0, hazard.pc_src_m);
        present_nop();
        check_bit("hazard.pc_src_w", 1'b0, hazard.pc_src_w);
        finish_test("execute flush");
    endtask

    task automatic test_flag_rule();
        load_zero(1'b1);
        run_and_check(IDX_ADD, COND_AL, '0, 1'b0, 1'b1);  // without the s bit zero stays set
        run_and_check(IDX_ADD, COND_EQ, '0, 1'b0, 1'b1);
        finish_test("flag update rule");
    endtask

    initial begin
        clk     = 1'b0;
        rst_n   = 1'b0;
        op      = OP_DATA;
        funct   = NOP_FUNCT;
        cond    = COND_AL;
        flags   = '0;
        flush_e = 1'b0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);

        test_reset();
        test_decode_table();
        test_conditions();
        test_branches();
        test_flush();
        test_flag_rule();

        $display("tests passed: %0d, tests failed: %0d, failed checks: %0d",
                 pass_count, fail_count, error_count);
        if (fail_count == 0 && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: verilog.f
ctrl_pkg.sv
instr_decoder.sv
cond_unit.sv
ctrl_pipeline.sv
pipelined_controller.sv
tb_pipelined_controller.sv
